// File: Bender.yml
package:
  name: idStage

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/idStagePkg.sv
      - verilog/instDecoder.sv
      - verilog/operandForward.sv
      - verilog/idExRegister.sv
      - verilog/idStage.sv
  - target: simulation
    include_dirs:
      - verilog
    files:
      - sim/idStageTb.sv

// File: sim/idStageTb.sv
`timescale 1ns/1ns
`default_nettype none

`include "idStage_macros.svh"

module idStageTb;

    logic                clk;
    logic                reset;
    idStagePkg::addrT    pc;
    idStagePkg::instT    inst;
    idStagePkg::dataT    regReadData [`NUM_READ_PORTS];
    logic                exRdEnable;
    idStagePkg::regIdxT  exRdIdx;
    idStagePkg::dataT    exRdData;
    idStagePkg::instIdxT exInstIdx;
    logic                memRdEnable;
    idStagePkg::regIdxT  memRdIdx;
    idStagePkg::dataT    memRdData;
    logic                regReadEnable [`NUM_READ_PORTS];
    idStagePkg::regIdxT  regReadIdx [`NUM_READ_PORTS];
    logic                stall;
    idStagePkg::addrT    issuePc;
    idStagePkg::instIdxT issueInstIdx;
    logic                issueValid;
    logic                issueRdEnable;
    idStagePkg::regIdxT  issueRdIdx;
    idStagePkg::dataT    issueOperand [`NUM_READ_PORTS];
    idStagePkg::dataT    issueImm;

    // Expected issue outputs after the next rising edge
    idStagePkg::addrT    expPc;
    idStagePkg::instIdxT expInstIdx;
    logic                expValid;
    logic                expRdEnable;
    idStagePkg::regIdxT  expRdIdx;
    idStagePkg::dataT    expOperand [`NUM_READ_PORTS];
    idStagePkg::dataT    expImm;
    int                  errorCount;
    int                  checkCount;

    // Instruction index per funct3 from the RV32I tables
    idStagePkg::instIdxT branchMap [8] = '{idStagePkg::INST_BEQ, idStagePkg::INST_BNE,
        idStagePkg::INST_NOP, idStagePkg::INST_NOP, idStagePkg::INST_BLT,
        idStagePkg::INST_BGE, idStagePkg::INST_BLTU, idStagePkg::INST_BGEU};
    idStagePkg::instIdxT loadMap [8] = '{idStagePkg::INST_LB, idStagePkg::INST_LH,
        idStagePkg::INST_LW, idStagePkg::INST_NOP, idStagePkg::INST_LBU,
        idStagePkg::INST_LHU, idStagePkg::INST_NOP, idStagePkg::INST_NOP};
    idStagePkg::instIdxT storeMap [8] = '{idStagePkg::INST_SB, idStagePkg::INST_SH,
        idStagePkg::INST_SW, idStagePkg::INST_NOP, idStagePkg::INST_NOP,
        idStagePkg::INST_NOP, idStagePkg::INST_NOP, idStagePkg::INST_NOP};
    idStagePkg::instIdxT riMap [8] = '{idStagePkg::INST_ADDI, idStagePkg::INST_SLLI,
        idStagePkg::INST_SLTI, idStagePkg::INST_SLTIU, idStagePkg::INST_XORI,
        idStagePkg::INST_SRLI, idStagePkg::INST_ORI, idStagePkg::INST_ANDI};
    idStagePkg::instIdxT rrMap [8] = '{idStagePkg::INST_ADD, idStagePkg::INST_SLL,
        idStagePkg::INST_SLT, idStagePkg::INST_SLTU, idStagePkg::INST_XOR,
        idStagePkg::INST_SRL, idStagePkg::INST_OR, idStagePkg::INST_AND};
    idStagePkg::instIdxT exInstPool [8] = '{idStagePkg::INST_NOP, idStagePkg::INST_ADDI,
        idStagePkg::INST_LW, idStagePkg::INST_LB, idStagePkg::INST_SW,
        idStagePkg::INST_ADD, idStagePkg::INST_LHU, idStagePkg::INST_SB};

    idStage uut (
        .clk           (clk),
        .reset         (reset),
        .pc            (pc),
        .inst          (inst),
        .regReadData   (regReadData),
        .exRdEnable    (exRdEnable),
        .exRdIdx       (exRdIdx),
        .exRdData      (exRdData),
        .exInstIdx     (exInstIdx),
        .memRdEnable   (memRdEnable),
        .memRdIdx      (memRdIdx),
        .memRdData     (memRdData),
        .regReadEnable (regReadEnable),
        .regReadIdx    (regReadIdx),
        .stall         (stall),
        .issuePc       (issuePc),
        .issueInstIdx  (issueInstIdx),
        .issueValid    (issueValid),
        .issueRdEnable (issueRdEnable),
        .issueRdIdx    (issueRdIdx),
        .issueOperand  (issueOperand),
        .issueImm      (issueImm)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic idStagePkg::dataT regFileValue(input idStagePkg::regIdxT idx);
        if (idx == '0) begin
            return '0;
        end
        return {idx, 3'b101, idx, ~idx, 14'h2a5c};
    endfunction

    // Register file answers in the same cycle
    always_comb begin
        for (int p = 0; p < `NUM_READ_PORTS; p++) begin
            regReadData[p] = regFileValue(regReadIdx[p]);
        end
    end

    function automatic logic isKnownOpcode(input logic [6:0] op);
        return op inside {`OP_LUI, `OP_AUIPC, `OP_JAL, `OP_JALR, `OP_BRANCH,
                          `OP_LOAD, `OP_STORE, `OP_RI, `OP_RR};
    endfunction

    // Kinds 0 to 8 pick a kept class and kinds 9 and 10 an undefined encoding
    function automatic idStagePkg::instT buildInst(input int kind);
        idStagePkg::instT w;
        int               r;
        w = $urandom;
        r = $urandom % 6;
        case (kind)
            0: w[6:0] = `OP_LUI;
            1: w[6:0] = `OP_AUIPC;
            2: w[6:0] = `OP_JAL;
            3: begin
                w[6:0]   = `OP_JALR;
                w[14:12] = 3'b000;
            end
            4: begin
                w[6:0]   = `OP_BRANCH;
                w[14:12] = (r < 2) ? 3'(r) : 3'(r + 2);
            end
            5: begin
                w[6:0]   = `OP_LOAD;
                w[14:12] = (r % 5 < 3) ? 3'(r % 5) : 3'(r % 5 + 1);
            end
            6: begin
                w[6:0]   = `OP_STORE;
                w[14:12] = 3'(r % 3);
            end
            7: w[6:0] = `OP_RI;
            8: w[6:0] = `OP_RR;
            9: begin
                while (isKnownOpcode(w[6:0])) begin
                    w[6:0] = 7'($urandom);
                end
            end
            default: begin              // Reserved funct3
                case (r % 4)
                    0: begin
                        w[6:0]   = `OP_JALR;
                        w[14:12] = 3'($urandom % 7 + 1);
                    end
                    1: begin
                        w[6:0]   = `OP_BRANCH;
                        w[14:12] = 3'b010 | 3'($urandom % 2);
                    end
                    2: begin
                        w[6:0]   = `OP_STORE;
                        w[14:12] = 3'($urandom % 5 + 3);
                    end
                    default: begin
                        w[6:0]   = `OP_LOAD;
                        w[14:12] = ($urandom % 3 == 0) ? 3'b011 : (3'b110 | 3'($urandom % 2));
                    end
                endcase
            end
        endcase
        return w;
    endfunction

    function automatic void decodeExpected(
        input  idStagePkg::instT    w,
        output idStagePkg::instIdxT idx,
        output logic                rdEn,
        output logic                src1En,
        output logic                src2En,
        output idStagePkg::dataT    imm
    );
        logic [2:0] f3;
        logic [6:0] op;
        f3     = w[14:12];
        op     = w[6:0];
        idx    = idStagePkg::INST_NOP;
        rdEn   = 1'b0;
        src1En = 1'b0;
        src2En = 1'b0;
        imm    = '0;
        case (op)
            `OP_LUI:    idx = idStagePkg::INST_LUI;
            `OP_AUIPC:  idx = idStagePkg::INST_AUIPC;
            `OP_JAL:    idx = idStagePkg::INST_JAL;
            `OP_JALR:   idx = (f3 == 3'b000) ? idStagePkg::INST_JALR : idStagePkg::INST_NOP;
            `OP_BRANCH: idx = branchMap[f3];
            `OP_LOAD:   idx = loadMap[f3];
            `OP_STORE:  idx = storeMap[f3];
            `OP_RI:     idx = (f3 == 3'b101 && w[30]) ? idStagePkg::INST_SRAI : riMap[f3];
            `OP_RR: begin
                idx = rrMap[f3];
                if (w[30] && f3 == 3'b000) idx = idStagePkg::INST_SUB;
                if (w[30] && f3 == 3'b101) idx = idStagePkg::INST_SRA;
            end
            default:    idx = idStagePkg::INST_NOP;
        endcase
        if (idx != idStagePkg::INST_NOP) begin
            rdEn   = !(op inside {`OP_BRANCH, `OP_STORE});
            src1En = !(op inside {`OP_LUI, `OP_AUIPC, `OP_JAL});
            src2En = op inside {`OP_BRANCH, `OP_STORE, `OP_RR};
            if (op == `OP_LUI || op == `OP_AUIPC) begin
                imm = {w[31:12], 12'h000};
            end else if (op == `OP_JAL) begin
                imm = $signed({w[31], w[19:12], w[20], w[30:21], 1'b0});
            end else if (op == `OP_BRANCH) begin
                imm = $signed({w[31], w[7], w[30:25], w[11:8], 1'b0});
            end else if (op == `OP_STORE) begin
                imm = $signed({w[31:25], w[11:7]});
            end else if (op == `OP_RI && f3[1:0] == 2'b01) begin
                imm = {27'b0, w[24:20]};                // Shift amount
            end else if (op != `OP_RR) begin
                imm = $signed(w[31:20]);
            end
        end
    endfunction

    function automatic idStagePkg::dataT forwardExpected(
        input logic en, input idStagePkg::regIdxT idx, input logic xEn,
        input idStagePkg::regIdxT xIdx, input idStagePkg::dataT xData, input logic mEn,
        input idStagePkg::regIdxT mIdx, input idStagePkg::dataT mData
    );
        if (!en || idx == '0) return '0;
        if (xEn && xIdx == idx) return xData;
        if (mEn && mIdx == idx) return mData;
        return regFileValue(idx);
    endfunction

    task automatic reportMismatch(input string what, input logic [31:0] got,
                                  input logic [31:0] want);
        errorCount++;
        $display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, what, got, want);
    endtask

    // One cycle of stimulus with the same-cycle checks and the next expectation
    task automatic applyCycle(
        input idStagePkg::instT w, input idStagePkg::addrT newPc, input logic xEn,
        input idStagePkg::regIdxT xIdx, input idStagePkg::dataT xData,
        input idStagePkg::instIdxT xInst, input logic mEn,
        input idStagePkg::regIdxT mIdx, input idStagePkg::dataT mData
    );
        idStagePkg::instIdxT idx;
        logic                rdEn;
        logic                en [`NUM_READ_PORTS];
        idStagePkg::regIdxT  src [`NUM_READ_PORTS];
        idStagePkg::dataT    immV;
        logic                hit;
        logic                stallV;
        @(negedge clk);
        inst        = w;
        pc          = newPc;
        exRdEnable  = xEn;
        exRdIdx     = xIdx;
        exRdData    = xData;
        exInstIdx   = xInst;
        memRdEnable = mEn;
        memRdIdx    = mIdx;
        memRdData   = mData;
        decodeExpected(w, idx, rdEn, en[0], en[1], immV);
        src[0] = en[0] ? w[19:15] : '0;
        src[1] = en[1] ? w[24:20] : '0;
        hit    = 1'b0;
        for (int p = 0; p < `NUM_READ_PORTS; p++) begin
            hit = hit | (en[p] && src[p] != '0 && xEn && xIdx == src[p]);
        end
        stallV = hit && (xInst inside {idStagePkg::INST_LB, idStagePkg::INST_LH,
                 idStagePkg::INST_LW, idStagePkg::INST_LBU, idStagePkg::INST_LHU});
        #1;
        checkCount++;
        for (int p = 0; p < `NUM_READ_PORTS; p++) begin
            if (regReadEnable[p] !== en[p]) begin
                reportMismatch("regReadEnable", regReadEnable[p], en[p]);
            end
            if (regReadIdx[p] !== src[p]) reportMismatch("regReadIdx", regReadIdx[p], src[p]);
            expOperand[p] = stallV ? '0
                : forwardExpected(en[p], src[p], xEn, xIdx, xData, mEn, mIdx, mData);
        end
        if (stall !== stallV) reportMismatch("stall", stall, stallV);
        expPc       = stallV ? '0 : newPc;              // Bubble on load use
        expInstIdx  = stallV ? idStagePkg::INST_NOP : idx;
        expValid    = !stallV && idx != idStagePkg::INST_NOP;
        expRdEnable = !stallV && rdEn;
        expRdIdx    = (!stallV && rdEn) ? w[11:7] : '0;
        expImm      = stallV ? '0 : immV;
    endtask

    task automatic randomContextCycle(input idStagePkg::instT w);
        idStagePkg::regIdxT xIdx;
        idStagePkg::regIdxT mIdx;
        int                 pick;
        pick = $urandom % 3;
        xIdx = (pick == 0) ? w[19:15] : (pick == 1) ? w[24:20] : 5'($urandom);
        pick = $urandom % 3;
        mIdx = (pick == 0) ? w[19:15] : (pick == 1) ? w[24:20] : 5'($urandom);
        applyCycle(w, $urandom & 32'hffff_fffc, ($urandom % 4) != 0, xIdx, $urandom,
                   exInstPool[$urandom % 8], ($urandom % 4) != 0, mIdx, $urandom);
    endtask

    // Load in EX feeding a source and the hold until the stall drops
    task automatic loadUseCase(input idStagePkg::instIdxT loadIdx);
        idStagePkg::instT   w;
        idStagePkg::addrT   pcV;
        idStagePkg::regIdxT src;
        int                 waited;
        w   = buildInst(8);
        pcV = $urandom & 32'hffff_fffc;
        if (w[19:15] == '0) w[19:15] = 5'd1;
        src = w[19:15];
        applyCycle(w, pcV, 1'b1, src, $urandom, loadIdx, 1'b0, '0, '0);
        waited = 0;
        while (stall === 1'b1 && waited < 4) begin
            applyCycle(w, pcV, 1'b0, '0, '0, idStagePkg::INST_NOP, 1'b0, '0, '0);
            waited++;
        end
        if (stall === 1'b1) begin
            errorCount++;
            $display("Stall stayed high after the load left EX");
        end
        // A store in EX on the same source issues normally
        applyCycle(w, pcV, 1'b1, src, $urandom, idStagePkg::INST_SW, 1'b0, '0, '0);
    endtask

    // Compare the registered outputs just after each rising edge
    initial begin
        forever begin
            @(posedge clk);
            #2;
            checkCount++;
            if (issuePc !== expPc) reportMismatch("issuePc", issuePc, expPc);
            if (issueInstIdx !== expInstIdx) begin
                reportMismatch("issueInstIdx", issueInstIdx, expInstIdx);
            end
            if (issueValid !== expValid) reportMismatch("issueValid", issueValid, expValid);
            if (issueRdEnable !== expRdEnable) begin
                reportMismatch("issueRdEnable", issueRdEnable, expRdEnable);
            end
            if (issueRdIdx !== expRdIdx) reportMismatch("issueRdIdx", issueRdIdx, expRdIdx);
            if (issueImm !== expImm) reportMismatch("issueImm", issueImm, expImm);
            for (int p = 0; p < `NUM_READ_PORTS; p++) begin
                if (issueOperand[p] !== expOperand[p])
                    reportMismatch("issueOperand", issueOperand[p], expOperand[p]);
            end
        end
    end

    initial begin
        #100000;
        $display("Simulation ran past its time limit");
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        void'($urandom(32'hb03978bd));
        errorCount  = 0;
        checkCount  = 0;
        reset       = 1'b1;
        pc          = '0;
        inst        = '0;
        exRdEnable  = 1'b0;
        exRdIdx     = '0;
        exRdData    = '0;
        exInstIdx   = idStagePkg::INST_NOP;
        memRdEnable = 1'b0;
        memRdIdx    = '0;
        memRdData   = '0;
        expPc       = '0;
        expInstIdx  = idStagePkg::INST_NOP;
        expValid    = 1'b0;
        expRdEnable = 1'b0;
        expRdIdx    = '0;
        expImm      = '0;
        for (int p = 0; p < `NUM_READ_PORTS; p++) begin
            expOperand[p] = '0;
        end
        for (int c = 0; c < 4; c++) begin
            @(negedge clk);
            if (stall !== 1'b0) reportMismatch("stall in reset", stall, 1'b0);
        end
        reset = 1'b0;
        for (int i = 0; i < 200; i++) begin             // Kept classes without forwarding
            applyCycle(buildInst($urandom % 9), $urandom & 32'hffff_fffc,
                       1'b0, '0, '0, idStagePkg::INST_NOP, 1'b0, '0, '0);
        end
        for (int i = 0; i < 60; i++) begin
            applyCycle(buildInst(9 + $urandom % 2), $urandom & 32'hffff_fffc,
                       1'b0, '0, '0, idStagePkg::INST_NOP, 1'b0, '0, '0);
        end
        for (int i = 0; i < 300; i++) begin
            randomContextCycle(buildInst($urandom % 9));
        end
        for (int i = 0; i < 20; i++) begin
            loadUseCase(exInstPool[2 + ($urandom % 2)]);
        end
        @(negedge clk);
        @(negedge clk);
        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule : idStageTb

`default_nettype wire

// File: src.f
+incdir+verilog
verilog/idStagePkg.sv
verilog/instDecoder.sv
verilog/operandForward.sv
verilog/idExRegister.sv
verilog/idStage.sv
sim/idStageTb.sv

// File: verilog/idExRegister.sv
`timescale 1ns/1ns
`default_nettype none

`include "idStage_macros.svh"

module idExRegister (
    input  wire logic                clk,
    input  wire logic                reset,
    input  wire idStagePkg::addrT    pc,
    input  wire idStagePkg::instIdxT instIdx,
    input  wire logic                instValid,
    input  wire logic                rdEnable,
    input  wire idStagePkg::regIdxT  rdIdx,
    input  wire idStagePkg::dataT    operand [`NUM_READ_PORTS],
    input  wire idStagePkg::dataT    imm,
    input  wire logic                exHit [`NUM_READ_PORTS],
    input  wire idStagePkg::instIdxT exInstIdx,
    output logic                     stall,
    output idStagePkg::addrT         issuePc,
    output idStagePkg::instIdxT      issueInstIdx,
    output logic                     issueValid,
    output logic                     issueRdEnable,
    output idStagePkg::regIdxT       issueRdIdx,
    output idStagePkg::dataT         issueOperand [`NUM_READ_PORTS],
    output idStagePkg::dataT         issueImm
);

    logic exIsLoad;
    logic anyExHit;

    // Load data is not ready until the end of MEM
    assign exIsLoad = exInstIdx inside {idStagePkg::INST_LB, idStagePkg::INST_LH,
                                        idStagePkg::INST_LW, idStagePkg::INST_LBU,
                                        idStagePkg::INST_LHU};

    always_comb begin
        anyExHit = 1'b0;
        for (int p = 0; p < `NUM_READ_PORTS; p++) begin
            anyExHit = anyExHit | exHit[p];
        end
    end

    assign stall = exIsLoad && anyExHit;

    always_ff @(posedge clk) begin
        if (reset || stall) begin       // Insert bubble
            issuePc       <= '0;
            issueInstIdx  <= idStagePkg::INST_NOP;
            issueValid    <= 1'b0;
            issueRdEnable <= 1'b0;
            issueRdIdx    <= '0;
            issueImm      <= '0;
            for (int p = 0; p < `NUM_READ_PORTS; p++) begin
                issueOperand[p] <= '0;
            end
        end else begin
            issuePc       <= pc;
            issueInstIdx  <= instIdx;
            issueValid    <= instValid;
            issueRdEnable <= rdEnable;
            issueRdIdx    <= rdIdx;
            issueImm      <= imm;
            for (int p = 0; p < `NUM_READ_PORTS; p++) begin
                issueOperand[p] <= operand[p];
            end
        end
    end

endmodule : idExRegister

`default_nettype wire

// File: verilog/idStage.sv
`timescale 1ns/1ns
`default_nettype none

`include "idStage_macros.svh"

module idStage (
    input  wire logic                clk,
    input  wire logic                reset,
    input  wire idStagePkg::addrT    pc,
    input  wire idStagePkg::instT    inst,
    input  wire idStagePkg::dataT    regReadData [`NUM_READ_PORTS],
    input  wire logic                exRdEnable,
    input  wire idStagePkg::regIdxT  exRdIdx,
    input  wire idStagePkg::dataT    exRdData,
    input  wire idStagePkg::instIdxT exInstIdx,
    input  wire logic                memRdEnable,
    input  wire idStagePkg::regIdxT  memRdIdx,
    input  wire idStagePkg::dataT    memRdData,
    output logic                     regReadEnable [`NUM_READ_PORTS],
    output idStagePkg::regIdxT       regReadIdx [`NUM_READ_PORTS],
    output logic                     stall,
    output idStagePkg::addrT         issuePc,
    output idStagePkg::instIdxT      issueInstIdx,
    output logic                     issueValid,
    output logic                     issueRdEnable,
    output idStagePkg::regIdxT       issueRdIdx,
    output idStagePkg::dataT         issueOperand [`NUM_READ_PORTS],
    output idStagePkg::dataT         issueImm
);

    wire idStagePkg::instIdxT instIdx;
    wire logic                instValid;
    wire logic                rdEnable;
    wire idStagePkg::regIdxT  rdIdx;
    wire idStagePkg::dataT    imm;
    wire idStagePkg::dataT    operand [`NUM_READ_PORTS];
    wire logic                exHit [`NUM_READ_PORTS];

    instDecoder decoder (
        .inst       (inst),
        .instIdx    (instIdx),
        .instValid  (instValid),
        .rdEnable   (rdEnable),
        .rdIdx      (rdIdx),
        .readEnable (regReadEnable),    // Straight to the register file
        .readIdx    (regReadIdx),
        .imm        (imm)
    );

    for (genvar p = 0; p < `NUM_READ_PORTS; p++) begin : genForward
        operandForward forward (
            .readEnable  (regReadEnable[p]),
            .readIdx     (regReadIdx[p]),
            .regData     (regReadData[p]),
            .exRdEnable  (exRdEnable),
            .exRdIdx     (exRdIdx),
            .exRdData    (exRdData),
            .memRdEnable (memRdEnable),
            .memRdIdx    (memRdIdx),
            .memRdData   (memRdData),
            .operand     (operand[p]),
            .exHit       (exHit[p])
        );
    end

    idExRegister idEx (
        .clk           (clk),
        .reset         (reset),
        .pc            (pc),
        .instIdx       (instIdx),
        .instValid     (instValid),
        .rdEnable      (rdEnable),
        .rdIdx         (rdIdx),
        .operand       (operand),
        .imm           (imm),
        .exHit         (exHit),
        .exInstIdx     (exInstIdx),
        .stall         (stall),
        .issuePc       (issuePc),
        .issueInstIdx  (issueInstIdx),
        .issueValid    (issueValid),
        .issueRdEnable (issueRdEnable),
        .issueRdIdx    (issueRdIdx),
        .issueOperand  (issueOperand),
        .issueImm      (issueImm)
    );

endmodule : idStage

`default_nettype wire

// File: verilog/idStagePkg.sv
`default_nettype none

`include "idStage_macros.svh"

package idStagePkg;

    typedef logic [`XLEN-1:0]          dataT;      // Operand or immediate
    typedef logic [`XLEN-1:0]          addrT;      // Program counter
    typedef logic [`INST_WIDTH-1:0]    instT;
    typedef logic [`REG_IDX_WIDTH-1:0] regIdxT;

    // One index per kept RV32I instruction, NOP marks a bubble
    typedef enum logic [5:0] {
        INST_NOP,
        INST_LUI,
        INST_AUIPC,
        INST_JAL,
        INST_JALR,
        INST_BEQ,
        INST_BNE,
        INST_BLT,
        INST_BGE,
        INST_BLTU,
        INST_BGEU,
        INST_LB,
        INST_LH,
        INST_LW,
        INST_LBU,
        INST_LHU,
        INST_SB,
        INST_SH,
        INST_SW,
        INST_ADDI,
        INST_SLTI,
        INST_SLTIU,
        INST_XORI,
        INST_ORI,
        INST_ANDI,
        INST_SLLI,
        INST_SRLI,
        INST_SRAI,
        INST_ADD,
        INST_SUB,
        INST_SLL,
        INST_SLT,
        INST_SLTU,
        INST_XOR,
        INST_SRL,
        INST_SRA,
        INST_OR,
        INST_AND
    } instIdxT;

endpackage : idStagePkg

`default_nettype wire

// File: verilog/idStage_macros.svh
`ifndef IDSTAGE_MACROS_SVH
`define IDSTAGE_MACROS_SVH

`define XLEN            32
`define INST_WIDTH      32
`define REG_IDX_WIDTH   5
`define NUM_READ_PORTS  2

`define OP_LUI          7'b0110111
`define OP_AUIPC        7'b0010111
`define OP_JAL          7'b1101111
`define OP_JALR         7'b1100111
`define OP_BRANCH       7'b1100011
`define OP_LOAD         7'b0000011
`define OP_STORE        7'b0100011
`define OP_RI           7'b0010011
`define OP_RR           7'b0110011

`define F3_JALR         3'b000

`define F3_BEQ          3'b000
`define F3_BNE          3'b001
`define F3_BLT          3'b100
`define F3_BGE          3'b101
`define F3_BLTU         3'b110
`define F3_BGEU         3'b111

`define F3_LB           3'b000
`define F3_LH           3'b001
`define F3_LW           3'b010
`define F3_LBU          3'b100
`define F3_LHU          3'b101

`define F3_SB           3'b000
`define F3_SH           3'b001
`define F3_SW           3'b010

// Register-immediate and register-register share the funct3 coding
`define F3_ADD          3'b000
`define F3_SLL          3'b001
`define F3_SLT          3'b010
`define F3_SLTU         3'b011
`define F3_XOR          3'b100
`define F3_SRx          3'b101
`define F3_OR           3'b110
`define F3_AND          3'b111
`define F3_SLLI         `F3_SLL
`define F3_SRxI         `F3_SRx

`endif

// File: verilog/instDecoder.sv
`timescale 1ns/1ns
`default_nettype none

`include "idStage_macros.svh"

module instDecoder (
    input  wire idStagePkg::instT   inst,
    output idStagePkg::instIdxT     instIdx,
    output logic                    instValid,
    output logic                    rdEnable,
    output idStagePkg::regIdxT      rdIdx,
    output logic                    readEnable [`NUM_READ_PORTS],
    output idStagePkg::regIdxT      readIdx [`NUM_READ_PORTS],
    output idStagePkg::dataT        imm
);

    logic [6:0]         opcode;
    logic [2:0]         funct3;
    logic               funct7b5;
    idStagePkg::regIdxT rd;
    idStagePkg::regIdxT rs1;
    idStagePkg::regIdxT rs2;
    idStagePkg::dataT   immI;
    idStagePkg::dataT   immS;
    idStagePkg::dataT   immB;
    idStagePkg::dataT   immU;
    idStagePkg::dataT   immJ;
    idStagePkg::dataT   immShamt;

    assign opcode   = inst[6:0];
    assign funct3   = inst[14:12];
    assign funct7b5 = inst[30];         // Selects SUB and arithmetic shifts
    assign rd       = inst[11:7];
    assign rs1      = inst[19:15];
    assign rs2      = inst[24:20];

    assign immI     = {{20{inst[31]}}, inst[31:20]};
    assign immS     = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign immB     = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    assign immU     = {inst[31:12], 12'b0};
    assign immJ     = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
    assign immShamt = {{(`XLEN-5){1'b0}}, inst[24:20]};   // Zero-extended shamt

    // Instruction index, NOP on any undefined encoding
    always_comb begin
        instIdx = idStagePkg::INST_NOP;
        case (opcode)
            `OP_LUI:   instIdx = idStagePkg::INST_LUI;
            `OP_AUIPC: instIdx = idStagePkg::INST_AUIPC;
            `OP_JAL:   instIdx = idStagePkg::INST_JAL;
            `OP_JALR: begin
                if (funct3 == `F3_JALR) instIdx = idStagePkg::INST_JALR;
            end
            `OP_BRANCH: begin
                case (funct3)
                    `F3_BEQ:  instIdx = idStagePkg::INST_BEQ;
                    `F3_BNE:  instIdx = idStagePkg::INST_BNE;
                    `F3_BLT:  instIdx = idStagePkg::INST_BLT;
                    `F3_BGE:  instIdx = idStagePkg::INST_BGE;
                    `F3_BLTU: instIdx = idStagePkg::INST_BLTU;
                    `F3_BGEU: instIdx = idStagePkg::INST_BGEU;
                    default:  instIdx = idStagePkg::INST_NOP;
                endcase
            end
            `OP_LOAD: begin
                case (funct3)
                    `F3_LB:  instIdx = idStagePkg::INST_LB;
                    `F3_LH:  instIdx = idStagePkg::INST_LH;
                    `F3_LW:  instIdx = idStagePkg::INST_LW;
                    `F3_LBU: instIdx = idStagePkg::INST_LBU;
                    `F3_LHU: instIdx = idStagePkg::INST_LHU;
                    default: instIdx = idStagePkg::INST_NOP;
                endcase
            end
            `OP_STORE: begin
                case (funct3)
                    `F3_SB:  instIdx = idStagePkg::INST_SB;
                    `F3_SH:  instIdx = idStagePkg::INST_SH;
                    `F3_SW:  instIdx = idStagePkg::INST_SW;
                    default: instIdx = idStagePkg::INST_NOP;
                endcase
            end
            `OP_RI: begin
                case (funct3)
                    `F3_ADD:  instIdx = idStagePkg::INST_ADDI;
                    `F3_SLT:  instIdx = idStagePkg::INST_SLTI;
                    `F3_SLTU: instIdx = idStagePkg::INST_SLTIU;
                    `F3_XOR:  instIdx = idStagePkg::INST_XORI;
                    `F3_OR:   instIdx = idStagePkg::INST_ORI;
                    `F3_AND:  instIdx = idStagePkg::INST_ANDI;
                    `F3_SLLI: instIdx = idStagePkg::INST_SLLI;
                    `F3_SRxI: instIdx = funct7b5 ? idStagePkg::INST_SRAI
                                                 : idStagePkg::INST_SRLI;
                    default:  instIdx = idStagePkg::INST_NOP;
                endcase
            end
            `OP_RR: begin
                case (funct3)
                    `F3_ADD:  instIdx = funct7b5 ? idStagePkg::INST_SUB
                                                 : idStagePkg::INST_ADD;
                    `F3_SLL:  instIdx = idStagePkg::INST_SLL;
                    `F3_SLT:  instIdx = idStagePkg::INST_SLT;
                    `F3_SLTU: instIdx = idStagePkg::INST_SLTU;
                    `F3_XOR:  instIdx = idStagePkg::INST_XOR;
                    `F3_SRx:  instIdx = funct7b5 ? idStagePkg::INST_SRA
                                                 : idStagePkg::INST_SRL;
                    `F3_OR:   instIdx = idStagePkg::INST_OR;
                    `F3_AND:  instIdx = idStagePkg::INST_AND;
                    default:  instIdx = idStagePkg::INST_NOP;
                endcase
            end
            default: instIdx = idStagePkg::INST_NOP;
        endcase
    end

    assign instValid = (instIdx != idStagePkg::INST_NOP);

    // Operand fields per format, all cleared for a bubble
    always_comb begin
        rdEnable = 1'b0;
        rdIdx    = '0;
        imm      = '0;
        for (int p = 0; p < `NUM_READ_PORTS; p++) begin
            readEnable[p] = 1'b0;
            readIdx[p]    = '0;
        end
        if (instValid) begin
            case (opcode)
                `OP_LUI, `OP_AUIPC: begin
                    rdEnable = 1'b1;
                    rdIdx    = rd;
                    imm      = immU;
                end
                `OP_JAL: begin
                    rdEnable = 1'b1;
                    rdIdx    = rd;
                    imm      = immJ;
                end
                `OP_JALR, `OP_LOAD, `OP_RI: begin
                    rdEnable      = 1'b1;
                    rdIdx         = rd;
                    readEnable[0] = 1'b1;
                    readIdx[0]    = rs1;
                    imm           = immI;
                    if (opcode == `OP_RI && (funct3 == `F3_SLLI || funct3 == `F3_SRxI)) begin
                        imm = immShamt;
                    end
                end
                `OP_BRANCH, `OP_STORE: begin
                    readEnable[0] = 1'b1;
                    readIdx[0]    = rs1;
                    readEnable[1] = 1'b1;
                    readIdx[1]    = rs2;
                    imm           = (opcode == `OP_BRANCH) ? immB : immS;
                end
                `OP_RR: begin
                    rdEnable      = 1'b1;
                    rdIdx         = rd;
                    readEnable[0] = 1'b1;
                    readIdx[0]    = rs1;
                    readEnable[1] = 1'b1;
                    readIdx[1]    = rs2;
                end
                default: rdEnable = 1'b0;
            endcase
        end
    end

endmodule : instDecoder

`default_nettype wire

// File: verilog/operandForward.sv
`timescale 1ns/1ns
`default_nettype none

`include "idStage_macros.svh"

module operandForward (
    input  wire logic               readEnable,
    input  wire idStagePkg::regIdxT readIdx,
    input  wire idStagePkg::dataT   regData,
    input  wire logic               exRdEnable,
    input  wire idStagePkg::regIdxT exRdIdx,
    input  wire idStagePkg::dataT   exRdData,
    input  wire logic               memRdEnable,
    input  wire idStagePkg::regIdxT memRdIdx,
    input  wire idStagePkg::dataT   memRdData,
    output idStagePkg::dataT        operand,
    output logic                    exHit
);

    logic exMatch;
    logic memMatch;

    assign exMatch  = exRdEnable && (exRdIdx == readIdx);
    assign memMatch = memRdEnable && (memRdIdx == readIdx);

    // Youngest producer wins
    always_comb begin
        operand = regData;
        exHit   = 1'b0;
        if (!readEnable || readIdx == '0) begin
            operand = '0;                       // x0 and unused ports
        end else if (exMatch) begin
            operand = exRdData;
            exHit   = 1'b1;
        end else if (memMatch) begin
            operand = memRdData;
        end
    end

endmodule : operandForward

`default_nettype wire
